//--- src.f
+incdir+src
src/z80_ctrl_pkg.sv
src/bus_cycle_if.sv
src/opcode_fetch_fsm.sv
src/nmi_ack_fsm.sv
src/instr_sequencer.sv
src/z80_control.sv
test/z80_control_tb.sv

//--- Bender.yml
package:
  name: z80_control

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/z80_ctrl_pkg.sv
      - src/bus_cycle_if.sv
      - src/opcode_fetch_fsm.sv
      - src/nmi_ack_fsm.sv
      - src/instr_sequencer.sv
      - src/z80_control.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/z80_control_tb.sv

//--- test/z80_control_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "z80_ctrl_settings.svh"

module z80_control_tb;

  import z80_ctrl_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int NOP_COUNT  = 8;
  localparam int INC_ROUNDS = 6;
  // upper bound on the cycles of all tests in order
  localparam int TEST_CYCLES = 10
    + 3 * `Z80_OCF_CYCLES
    + (NOP_COUNT + 2) * `Z80_OCF_CYCLES
    + INC_ROUNDS * (3 * `Z80_OCF_CYCLES + 1)
    + 6 * `Z80_OCF_CYCLES + `Z80_NMI_CYCLES;
  // longest wait for any single event
  localparam int WAIT_LIMIT = 4 * (`Z80_OCF_CYCLES + `Z80_NMI_CYCLES);

  logic clk, rst_L, nmi_L;
  logic [`Z80_DATA_W-1:0] data_in;
  logic m1_L, mreq_L, iorq_L, rd_L, rfsh_L;
  logic ld_pch, ld_pcl, drive_pch, drive_pcl;
  logic ld_b, ld_c, ld_d, ld_e, ld_h, ld_l, ld_a;
  logic drive_b, drive_c, drive_d, drive_e, drive_h, drive_l, drive_a;
  logic ld_f_data, drive_reg_addr, drive_reg_data, drive_alu_addr, drive_alu_data;
  alu_op_e alu_op;

  // bit i of reg_ld and reg_drv is register i of reg_names
  logic [6:0] reg_ld;
  logic [6:0] reg_drv;
  logic [3:0] pc_ctl;
  logic [4:0] dp_ctl;
  string reg_names [7] = '{"b", "c", "d", "e", "h", "l", "a"};
  string pc_names [4]  = '{"ld_pch", "ld_pcl", "drive_pch", "drive_pcl"};

  assign reg_ld  = {ld_a, ld_l, ld_h, ld_e, ld_d, ld_c, ld_b};
  assign reg_drv = {drive_a, drive_l, drive_h, drive_e, drive_d, drive_c, drive_b};
  assign pc_ctl  = {drive_pcl, drive_pch, ld_pcl, ld_pch};
  assign dp_ctl  = {ld_f_data, drive_reg_addr, drive_reg_data, drive_alu_addr, drive_alu_data};

  integer seed;
  int err_cnt;
  int check_cnt;

  // memory model state
  opcode_t opcode_q[$];
  logic    rd_prev;

  z80_control dut (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // --------------------------------------------------
  // memory model
  // --------------------------------------------------

  // queue head sits on the bus while rd_L is low
  // an empty queue reads as 0xff
  always @(negedge clk) begin
    rd_prev <= rd_L;
    if (rd_L === 1'b0) begin
      data_in <= (opcode_q.size() > 0) ? opcode_q[0].raw : 8'hff;
    end else begin
      data_in <= 8'hff;
    end
    // the read just ended so the opcode is latched
    if (rd_prev === 1'b0 && rd_L === 1'b1 && opcode_q.size() > 0) begin
      void'(opcode_q.pop_front());
    end
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_bit(input string name, input logic actual, input logic expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_alu_op(input string name, input alu_op_e actual, input alu_op_e expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %s, got %s", $time, name, expected.name(),
               actual.name());
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    check_cnt++;
    if (actual != expected) begin
      err_cnt++;
      $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic test_result(input string name, input int errs_before);
    $display("%s: %s", name, (err_cnt == errs_before) ? "passed" : "failed");
  endtask

  // --------------------------------------------------
  // sync helpers sampling on the falling edge
  // --------------------------------------------------

  // first clock of an opcode read
  function automatic bit fetch_starts();
    return (rd_L === 1'b0) && (rd_prev === 1'b1);
  endfunction

  task automatic wait_fetch_start(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
      @(negedge clk);
      ok = fetch_starts();
    end
    if (!ok) begin
      err_cnt++;
      $display("no opcode fetch started within %0d cycles at %0t", WAIT_LIMIT, $time);
    end
  endtask

  // finds T4 of a fetch where opcodes for the next fetch can be queued
  task automatic sync_fetch_end();
    int  n;
    bit  found;
    found = 1'b0;
    for (n = 0; n < WAIT_LIMIT && !found; n++) begin
      @(negedge clk);
      found = (rfsh_L === 1'b0) && (rd_prev === 1'b1);
    end
    if (!found) begin
      err_cnt++;
      $display("no refresh clock seen within %0d cycles at %0t", WAIT_LIMIT, $time);
    end
  endtask

  task automatic check_idle();
    check_bit("m1_L", m1_L, 1'b1);
    check_bit("mreq_L", mreq_L, 1'b1);
    check_bit("iorq_L", iorq_L, 1'b1);
    check_bit("rd_L", rd_L, 1'b1);
    check_bit("rfsh_L", rfsh_L, 1'b1);
    check_bit("pc load or drive", |pc_ctl, 1'b0);
    check_bit("register load", |reg_ld, 1'b0);
    check_bit("register drive", |reg_drv, 1'b0);
    check_bit("datapath drive", |dp_ctl, 1'b0);
    check_alu_op("alu_op", alu_op, ALU_NOP);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic reset_test();
    int errs;
    int k;
    errs = err_cnt;
    rst_L <= 1'b0;
    for (k = 0; k < 8; k++) begin
      @(negedge clk);
      check_idle();
    end
    rst_L <= 1'b1;
    // fetch starts right away
    @(negedge clk);
    check_bit("m1_L", m1_L, 1'b0);
    check_bit("mreq_L", mreq_L, 1'b0);
    check_bit("rd_L", rd_L, 1'b0);
    test_result("reset", errs);
  endtask

  task automatic fetch_shape_test();
    int      errs;
    int      k;
    int      i;
    bit      ok;
    opcode_t op;
    errs = err_cnt;
    op.raw = 8'h00;
    sync_fetch_end();
    opcode_q.push_back(op);
    wait_fetch_start(ok);
    for (k = 0; k < `Z80_OCF_CYCLES && ok; k++) begin
      if (k > 0) @(negedge clk);
      // read in T1 and T2 then refresh in T3 and T4
      check_bit("m1_L", m1_L, k >= 2);
      check_bit("rd_L", rd_L, k >= 2);
      check_bit("rfsh_L", rfsh_L, k < 2);
      check_bit("mreq_L", mreq_L, 1'b0);
      check_bit("iorq_L", iorq_L, 1'b1);
      for (i = 0; i < 4; i++) begin
        check_bit(pc_names[i], pc_ctl[i], k == 0);
      end
      check_bit("drive_reg_addr", drive_reg_addr, k == 0);
      check_bit("drive_alu_addr", drive_alu_addr, k == 0);
      check_alu_op("alu_op", alu_op, (k == 0) ? ALU_INC16 : ALU_NOP);
    end
    test_result("fetch shape", errs);
  endtask

  task automatic nop_stream_test();
    logic [7:0] codes [NOP_COUNT];
    int         errs;
    int         i;
    int         gap;
    bit         ok;
    opcode_t    op;
    // nop, inc (hl), dec a, halt, add a b, jp, rlca, ld (hl) n
    codes = '{8'h00, 8'h34, 8'h3d, 8'h76, 8'h80, 8'hc3, 8'h07, 8'h36};
    errs = err_cnt;
    sync_fetch_end();
    for (i = 0; i < NOP_COUNT; i++) begin
      op.raw = codes[i];
      opcode_q.push_back(op);
    end
    wait_fetch_start(ok);
    for (i = 0; i < NOP_COUNT && ok; i++) begin
      gap = 0;
      ok = 1'b0;
      while (!ok && gap < WAIT_LIMIT) begin
        @(negedge clk);
        gap++;
        check_bit("register load", |reg_ld, 1'b0);
        ok = fetch_starts();
      end
      check_count($sformatf("fetch spacing after %h", codes[i]), gap, `Z80_OCF_CYCLES);
    end
    test_result("nop stream", errs);
  endtask

  task automatic inc_test();
    int         errs;
    int         round;
    int         idx;
    int         k;
    int         i;
    bit         ok;
    bit         fetched;
    reg_sel_e   r;
    opcode_t    op;
    logic [6:0] want;
    errs = err_cnt;
    for (round = 0; round < INC_ROUNDS; round++) begin
      // pick from b..l and a since (hl) is not a register
      idx = $unsigned($random(seed)) % 7;
      r = (idx == 6) ? A : reg_sel_e'(idx);
      op.fields.x = 2'd0;
      op.fields.y = r;
      op.fields.z = 3'd4;
      want = 7'b1 << idx;
      sync_fetch_end();
      opcode_q.push_back(op);
      wait_fetch_start(ok);
      fetched = 1'b0;
      for (k = 1; k <= WAIT_LIMIT && ok && !fetched; k++) begin
        @(negedge clk);
        fetched = fetch_starts();
        if (k == `Z80_OCF_CYCLES) begin
          // execute clock right after the fetch
          for (i = 0; i < 7; i++) begin
            check_bit({"ld_", reg_names[i]}, reg_ld[i], want[i]);
            check_bit({"drive_", reg_names[i]}, reg_drv[i], want[i]);
          end
          check_bit("ld_f_data", ld_f_data, 1'b1);
          check_bit("drive_alu_data", drive_alu_data, 1'b1);
          check_bit("drive_reg_data", drive_reg_data, r != A);
          check_alu_op("alu_op", alu_op, ALU_INC8);
        end else begin
          check_bit("register load", |reg_ld, 1'b0);
        end
        if (fetched) begin
          check_count({"fetch spacing after INC ", r.name()}, k, `Z80_OCF_CYCLES + 1);
        end
      end
      if (ok && !fetched) begin
        err_cnt++;
        $display("no fetch followed INC %s within %0d cycles at %0t", r.name(), WAIT_LIMIT,
                 $time);
      end
    end
    test_result("inc r", errs);
  endtask

  task automatic nmi_test();
    int      errs;
    int      k;
    bit      ok;
    bit      ack;
    opcode_t op;
    errs = err_cnt;
    op.raw = 8'h00;
    sync_fetch_end();
    opcode_q.push_back(op);
    wait_fetch_start(ok);
    // falling edge in the middle of the instruction
    @(negedge clk);
    nmi_L <= 1'b0;
    ack = 1'b0;
    for (k = 1; k < WAIT_LIMIT && ok && !ack; k++) begin
      @(negedge clk);
      ack = (m1_L === 1'b0) && (rd_L === 1'b1);
    end
    if (!ack) begin
      err_cnt++;
      $display("no nmi acknowledge cycle seen at %0t", $time);
    end else begin
      check_count("nmi acknowledge start", k, `Z80_OCF_CYCLES);
      for (k = 0; k < `Z80_NMI_CYCLES; k++) begin
        if (k > 0) @(negedge clk);
        check_bit("m1_L", m1_L, k >= 4);
        check_bit("iorq_L", iorq_L, !(k == 2 || k == 3));
        check_bit("mreq_L", mreq_L, 1'b1);
        check_bit("rd_L", rd_L, 1'b1);
      end
      @(negedge clk);
      check_bit("fetch start after acknowledge", fetch_starts(), 1'b1);
      // low level alone must not start another one
      for (k = 0; k < 3 * `Z80_OCF_CYCLES; k++) begin
        @(negedge clk);
        check_bit("iorq_L", iorq_L, 1'b1);
      end
    end
    nmi_L <= 1'b1;
    test_result("nmi acknowledge", errs);
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin
    #(2 * TEST_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired, run did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed      = 17;
    err_cnt   = 0;
    check_cnt = 0;
    rst_L     = 1'b0;
    nmi_L     = 1'b1;
    data_in   = 8'hff;
    rd_prev   = 1'b1;
    reset_test();
    fetch_shape_test();
    nop_stream_test();
    inc_test();
    nmi_test();
    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : z80_control_tb

`default_nettype wire

//--- src/z80_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "z80_ctrl_settings.svh"

// control unit top, sequencer plus one FSM per machine cycle type
module z80_control (
  input  logic                   clk,
  input  logic                   rst_L,
  input  logic                   nmi_L,
  input  logic [`Z80_DATA_W-1:0] data_in,

  output logic                   m1_L,
  output logic                   mreq_L,
  output logic                   iorq_L,
  output logic                   rd_L,
  output logic                   rfsh_L,

  output logic                   ld_pch,
  output logic                   ld_pcl,
  output logic                   drive_pch,
  output logic                   drive_pcl,

  output logic                   ld_b,
  output logic                   ld_c,
  output logic                   ld_d,
  output logic                   ld_e,
  output logic                   ld_h,
  output logic                   ld_l,
  output logic                   ld_a,
  output logic                   drive_b,
  output logic                   drive_c,
  output logic                   drive_d,
  output logic                   drive_e,
  output logic                   drive_h,
  output logic                   drive_l,
  output logic                   drive_a,

  output logic                   ld_f_data,
  output logic                   drive_reg_addr,
  output logic                   drive_reg_data,
  output logic                   drive_alu_addr,
  output logic                   drive_alu_data,
  output z80_ctrl_pkg::alu_op_e  alu_op
);

  // --------------------------------------------------
  // machine cycle channels
  // --------------------------------------------------
  bus_cycle_if ocf_bus ();
  bus_cycle_if nmi_bus ();

  opcode_fetch_fsm u_ocf (
    .clk   (clk),
    .rst_L (rst_L),
    .bus   (ocf_bus)
  );

  nmi_ack_fsm u_nmi (
    .clk   (clk),
    .rst_L (rst_L),
    .bus   (nmi_bus)
  );

  // every other port has the same name on both sides
  instr_sequencer u_seq (
    .ocf (ocf_bus),
    .nmi (nmi_bus),
    .*
  );

endmodule : z80_control

`default_nettype wire

//--- src/instr_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "z80_ctrl_settings.svh"

// macro state FSM, opcode decode and bus strobe arbitration
module instr_sequencer (
  input  logic                   clk,
  input  logic                   rst_L,
  input  logic                   nmi_L,
  input  logic [`Z80_DATA_W-1:0] data_in,

  bus_cycle_if.ctrl              ocf,
  bus_cycle_if.ctrl              nmi,

  // z80 bus strobes
  output logic                   m1_L,
  output logic                   mreq_L,
  output logic                   iorq_L,
  output logic                   rd_L,
  output logic                   rfsh_L,

  // program counter
  output logic                   ld_pch,
  output logic                   ld_pcl,
  output logic                   drive_pch,
  output logic                   drive_pcl,

  // general registers
  output logic                   ld_b,
  output logic                   ld_c,
  output logic                   ld_d,
  output logic                   ld_e,
  output logic                   ld_h,
  output logic                   ld_l,
  output logic                   ld_a,
  output logic                   drive_b,
  output logic                   drive_c,
  output logic                   drive_d,
  output logic                   drive_e,
  output logic                   drive_h,
  output logic                   drive_l,
  output logic                   drive_a,

  // flags, regfile and alu bus drives
  output logic                   ld_f_data,
  output logic                   drive_reg_addr,
  output logic                   drive_reg_data,
  output logic                   drive_alu_addr,
  output logic                   drive_alu_data,
  output z80_ctrl_pkg::alu_op_e  alu_op
);

  import z80_ctrl_pkg::*;

  // IDLE only exists while reset is held
  typedef enum logic [2:0] {
    IDLE,
    FETCH_0,
    FETCH_1,
    FETCH_2,
    FETCH_3,
    INC_0,
    NMI_WAIT
  } seq_state_e;

  seq_state_e state, next_state;
  seq_state_e end_state;

  opcode_t    opcode;
  reg_sel_e   inc_reg;
  logic       is_inc_r;

  logic       nmi_L_d1;
  logic       nmi_fall;
  logic       nmi_pend;
  logic       nmi_active;

  // --------------------------------------------------
  // state and opcode latch
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_L) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // FETCH_1 is the last clock with rd_L low
  always_ff @(posedge clk) begin
    if (state == FETCH_1) begin
      opcode.raw <= data_in;
    end
  end

  assign inc_reg  = reg_sel_e'(opcode.fields.y);
  // INC r is x=0 z=4, INC (HL) needs a memory cycle and runs as a NOP
  assign is_inc_r = (opcode.fields.x == 2'd0) && (opcode.fields.z == 3'd4) &&
                    (inc_reg != HL_MEM);

  // --------------------------------------------------
  // nmi edge detect and pending flag
  // --------------------------------------------------
  assign nmi_fall = nmi_L_d1 && !nmi_L;

  always_ff @(posedge clk) begin
    if (!rst_L) begin
      nmi_L_d1   <= 1'b1;
      nmi_pend   <= 1'b0;
      nmi_active <= 1'b0;
    end else begin
      nmi_L_d1 <= nmi_L;
      // a fresh edge wins over the clear
      if (nmi_fall) begin
        nmi_pend <= 1'b1;
      end else if (nmi.start) begin
        nmi_pend <= 1'b0;
      end
      // busy from start to done, keeps start to a single pulse
      if (nmi.start) begin
        nmi_active <= 1'b1;
      end else if (nmi.done) begin
        nmi_active <= 1'b0;
      end
    end
  end

  assign ocf.start = (state == FETCH_0);
  assign nmi.start = (state == NMI_WAIT) && !nmi_active;

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  // where every instruction goes when it finishes
  assign end_state = nmi_pend ? NMI_WAIT : FETCH_0;

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    next_state = FETCH_0;
      FETCH_0: next_state = FETCH_1;
      FETCH_1: next_state = FETCH_2;
      FETCH_2: next_state = FETCH_3;
      FETCH_3: begin
        if (ocf.done) begin
          next_state = is_inc_r ? INC_0 : end_state;
        end
      end
      INC_0:   next_state = end_state;
      NMI_WAIT: begin
        if (nmi.done) begin
          next_state = FETCH_0;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  // --------------------------------------------------
  // datapath strobes
  // --------------------------------------------------
  always_comb begin
    ld_pch         = 1'b0;
    ld_pcl         = 1'b0;
    drive_pch      = 1'b0;
    drive_pcl      = 1'b0;
    ld_b           = 1'b0;
    ld_c           = 1'b0;
    ld_d           = 1'b0;
    ld_e           = 1'b0;
    ld_h           = 1'b0;
    ld_l           = 1'b0;
    ld_a           = 1'b0;
    drive_b        = 1'b0;
    drive_c        = 1'b0;
    drive_d        = 1'b0;
    drive_e        = 1'b0;
    drive_h        = 1'b0;
    drive_l        = 1'b0;
    drive_a        = 1'b0;
    ld_f_data      = 1'b0;
    drive_reg_addr = 1'b0;
    drive_reg_data = 1'b0;
    drive_alu_addr = 1'b0;
    drive_alu_data = 1'b0;
    alu_op         = ALU_NOP;

    case (state)
      // pc goes out on the address bus and comes back incremented
      FETCH_0: begin
        ld_pch         = 1'b1;
        ld_pcl         = 1'b1;
        drive_pch      = 1'b1;
        drive_pcl      = 1'b1;
        drive_reg_addr = 1'b1;
        drive_alu_addr = 1'b1;
        alu_op         = ALU_INC16;
      end
      // r through the 8-bit alu and back into r, flags follow
      INC_0: begin
        alu_op         = ALU_INC8;
        drive_alu_data = 1'b1;
        ld_f_data      = 1'b1;
        // A sits beside the regfile with its own data drive
        drive_reg_data = (inc_reg != A);
        case (inc_reg)
          B: begin
            ld_b    = 1'b1;
            drive_b = 1'b1;
          end
          C: begin
            ld_c    = 1'b1;
            drive_c = 1'b1;
          end
          D: begin
            ld_d    = 1'b1;
            drive_d = 1'b1;
          end
          E: begin
            ld_e    = 1'b1;
            drive_e = 1'b1;
          end
          H: begin
            ld_h    = 1'b1;
            drive_h = 1'b1;
          end
          L: begin
            ld_l    = 1'b1;
            drive_l = 1'b1;
          end
          A: begin
            ld_a    = 1'b1;
            drive_a = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  // --------------------------------------------------
  // bus lines, owner picked by macro state
  // --------------------------------------------------
  always_comb begin
    m1_L   = 1'b1;
    mreq_L = 1'b1;
    iorq_L = 1'b1;
    rd_L   = 1'b1;
    rfsh_L = 1'b1;

    case (state)
      FETCH_0, FETCH_1, FETCH_2, FETCH_3: begin
        m1_L   = ocf.m1_L;
        mreq_L = ocf.mreq_L;
        iorq_L = ocf.iorq_L;
        rd_L   = ocf.rd_L;
        rfsh_L = ocf.rfsh_L;
      end
      NMI_WAIT: begin
        m1_L   = nmi.m1_L;
        mreq_L = nmi.mreq_L;
        iorq_L = nmi.iorq_L;
        rd_L   = nmi.rd_L;
        rfsh_L = nmi.rfsh_L;
      end
      default: ;
    endcase
  end

  // only one cycle FSM may own the bus at a time
  one_start: assert property (@(posedge clk) disable iff (!rst_L)
    !(ocf.start && nmi.start));

endmodule : instr_sequencer

`default_nettype wire

//--- src/nmi_ack_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "z80_ctrl_settings.svh"

// nmi acknowledge cycle, an M1 with two automatic wait states
module nmi_ack_fsm (
  input  logic       clk,
  input  logic       rst_L,
  bus_cycle_if.cycle bus
);

  typedef enum logic [2:0] {
    T1  = 3'd0,
    T2  = 3'd1,
    TW1 = 3'd2,
    TW2 = 3'd3,
    T3  = 3'd4,
    T4  = 3'd5
  } nmi_state_e;

  nmi_state_e state, next_state;

  always_ff @(posedge clk) begin
    if (!rst_L) begin
      state <= T1;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      T1:      next_state = bus.start ? T2 : T1;
      T2:      next_state = TW1;
      TW1:     next_state = TW2;
      TW2:     next_state = T3;
      T3:      next_state = T4;
      default: next_state = T1;
    endcase
  end

  // --------------------------------------------------
  // strobes
  // --------------------------------------------------
  always_comb begin
    bus.m1_L   = 1'b1;
    bus.iorq_L = 1'b1;
    bus.done   = 1'b0;
    // no memory access and no refresh in this version of the cycle
    bus.mreq_L = 1'b1;
    bus.rd_L   = 1'b1;
    bus.rfsh_L = 1'b1;

    case (state)
      T1:  bus.m1_L = !bus.start;
      T2:  bus.m1_L = 1'b0;
      // m1 with iorq is the acknowledge itself
      TW1, TW2: begin
        bus.m1_L   = 1'b0;
        bus.iorq_L = 1'b0;
      end
      T4:  bus.done = 1'b1;
      default: ;
    endcase
  end

  // iorq alone would look like a plain io access
  iorq_has_m1: assert property (@(posedge clk) disable iff (!rst_L)
    !bus.iorq_L |-> !bus.m1_L);

  start_in_t1: assert property (@(posedge clk) disable iff (!rst_L)
    bus.start |-> state == T1);

  done_on_time: assert property (@(posedge clk) disable iff (!rst_L)
    bus.start |-> ##(`Z80_NMI_CYCLES - 1) bus.done);

endmodule : nmi_ack_fsm

`default_nettype wire

//--- src/opcode_fetch_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "z80_ctrl_settings.svh"

// M1 opcode fetch, four T states including the two refresh clocks
module opcode_fetch_fsm (
  input  logic       clk,
  input  logic       rst_L,
  bus_cycle_if.cycle bus
);

  typedef enum logic [1:0] {
    T1 = 2'd0,
    T2 = 2'd1,
    T3 = 2'd2,
    T4 = 2'd3
  } ocf_state_e;

  ocf_state_e state, next_state;

  always_ff @(posedge clk) begin
    if (!rst_L) begin
      state <= T1;
    end else begin
      state <= next_state;
    end
  end

  // idle in T1 until start, then walk straight through
  always_comb begin
    case (state)
      T1:      next_state = bus.start ? T2 : T1;
      T2:      next_state = T3;
      T3:      next_state = T4;
      default: next_state = T1;
    endcase
  end

  // --------------------------------------------------
  // strobes
  // --------------------------------------------------
  always_comb begin
    bus.m1_L   = 1'b1;
    bus.mreq_L = 1'b1;
    bus.rd_L   = 1'b1;
    bus.rfsh_L = 1'b1;
    bus.done   = 1'b0;
    // never an io cycle
    bus.iorq_L = 1'b1;

    case (state)
      // strobes go out in the start cycle itself
      T1: begin
        if (bus.start) begin
          bus.m1_L   = 1'b0;
          bus.mreq_L = 1'b0;
          bus.rd_L   = 1'b0;
        end
      end
      // opcode is on the bus at the end of T2
      T2: begin
        bus.m1_L   = 1'b0;
        bus.mreq_L = 1'b0;
        bus.rd_L   = 1'b0;
      end
      // dram refresh, mreq stays low with rfsh
      T3: begin
        bus.mreq_L = 1'b0;
        bus.rfsh_L = 1'b0;
      end
      T4: begin
        bus.mreq_L = 1'b0;
        bus.rfsh_L = 1'b0;
        bus.done   = 1'b1;
      end
      default: ;
    endcase
  end

  // sequencer only starts us while idle
  start_in_t1: assert property (@(posedge clk) disable iff (!rst_L)
    bus.start |-> state == T1);

  // a read is always a memory read here
  rd_has_mreq: assert property (@(posedge clk) disable iff (!rst_L)
    !bus.rd_L |-> !bus.mreq_L);

  // done lands on the last clock of the cycle
  done_on_time: assert property (@(posedge clk) disable iff (!rst_L)
    bus.start |-> ##(`Z80_OCF_CYCLES - 1) bus.done);

endmodule : opcode_fetch_fsm

`default_nettype wire

//--- src/bus_cycle_if.sv
`timescale 1ns/10ps
`default_nettype none

// one machine cycle channel between the sequencer and a cycle FSM
interface bus_cycle_if;

  // one clock pulse, only while the FSM sits idle in T1
  logic start;
  // one clock pulse in the last T state
  logic done;

  // active low Z80 bus strobes as this FSM wants them
  logic m1_L;
  logic mreq_L;
  logic iorq_L;
  logic rd_L;
  logic rfsh_L;

  // sequencer side
  modport ctrl (
    output start,
    input  done, m1_L, mreq_L, iorq_L, rd_L, rfsh_L
  );

  // cycle FSM side
  modport cycle (
    input  start,
    output done, m1_L, mreq_L, iorq_L, rd_L, rfsh_L
  );

endinterface : bus_cycle_if

`default_nettype wire

//--- src/z80_ctrl_pkg.sv
`default_nettype none

`include "z80_ctrl_settings.svh"

package z80_ctrl_pkg;

  // --------------------------------------------------
  // opcode byte
  // --------------------------------------------------

  // classic x/y/z split of the first opcode byte
  //   x selects the quadrant, y is usually the register, z the operation
  typedef struct packed {
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
  } opcode_fields_t;

  // raw view is what comes off the bus, field view is what the decoder reads
  typedef union packed {
    logic [`Z80_DATA_W-1:0] raw;
    opcode_fields_t         fields;
  } opcode_t;

  // --------------------------------------------------
  // register select, encoded as the y field
  // --------------------------------------------------
  typedef enum logic [2:0] {
    B      = 3'd0,
    C      = 3'd1,
    D      = 3'd2,
    E      = 3'd3,
    H      = 3'd4,
    L      = 3'd5,
    // (HL) means the memory byte, not a register
    HL_MEM = 3'd6,
    A      = 3'd7
  } reg_sel_e;

  // alu operations the control unit asks for
  typedef enum logic [`Z80_ALU_OP_W-1:0] {
    ALU_NOP,
    // 8-bit increment on the data side, sets flags
    ALU_INC8,
    // 16-bit increment on the address side, used for pc + 1
    ALU_INC16
  } alu_op_e;

endpackage : z80_ctrl_pkg

`default_nettype wire

//--- src/z80_ctrl_settings.svh
`ifndef Z80_CTRL_SETTINGS_SVH
`define Z80_CTRL_SETTINGS_SVH

// --------------------------------------------------
// bus and datapath widths
// --------------------------------------------------

// data bus, one opcode byte per fetch
`define Z80_DATA_W 8

// alu operation select
`define Z80_ALU_OP_W 4

// --------------------------------------------------
// machine cycle lengths in clocks, start to done
// --------------------------------------------------

// M1 opcode fetch, T1..T4
`define Z80_OCF_CYCLES 4
// nmi acknowledge, T1 T2 TW1 TW2 T3 T4
`define Z80_NMI_CYCLES 6

`endif
